/* exec_cluster.f */
+incdir+src
src/exec_pkg.sv
src/delay_pipe.sv
src/alu.sv
src/branch_unit.sv
src/imul.sv
src/inflight_counter.sv
src/issue_ctrl.sv
src/exec_cluster.sv
bench/exec_cluster_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the execution cluster testbench with verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

verilator --binary --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module exec_cluster_tb -Mdir obj_dir -f exec_cluster.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vexec_cluster_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

/* bench/exec_cluster_tb.sv */
// ------------------------------
// cluster testbench with vector
// table, reference model and
// scoreboard by tag
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "exec_params.svh"

module exec_cluster_tb import exec_pkg::*; ();

  localparam int SEED       = 28;
  localparam int LAT        = `IMUL_LATENCY;
  localparam int NTAGS      = 1 << `TAG_WIDTH;
  localparam int WAIT_LIMIT = 100;

  typedef struct {
    string            name;
    fu_sel_t          fu;
    logic [3:0]       op;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imm;
    tag_t             tag;
    int               gap;     // idle cycles before the offer
    int               stalls;  // expected cycles with issue_ready low or -1
  } vec_t;

  logic             clock;
  logic             reset;
  logic             issue;
  logic             drain;
  fu_sel_t          fu_sel;
  alu_type_t        alu_type;
  br_type_t         br_type;
  imul_type_t       imul_type;
  tag_t             tag;
  logic [`XLEN-1:0] in1, in2, pc, imm;
  logic             result_valid, br_valid, br_taken, issue_ready, drained;
  tag_t             result_tag, br_tag;
  logic [`XLEN-1:0] result_data, br_addr;

  // scoreboard with one slot per tag
  bit               pend     [NTAGS];
  bit               is_br    [NTAGS];
  bit               exp_tk   [NTAGS];
  logic [`XLEN-1:0] exp_val  [NTAGS];
  int               exp_cyc  [NTAGS];
  string            exp_name [NTAGS];

  vec_t vec_table[$];
  int   cycle        = 0;
  int   checks       = 0;
  int   value_errors = 0;
  int   other_errors = 0;
  int   last_mul_cyc = -1;
  tag_t next_tag     = '0;

  exec_cluster u_exec_cluster (
    .clock(clock), .reset(reset), .issue(issue), .fu_sel(fu_sel),
    .alu_type(alu_type), .br_type(br_type), .imul_type(imul_type), .tag(tag),
    .in1(in1), .in2(in2), .pc(pc), .imm(imm),
    .result_valid(result_valid), .result_tag(result_tag), .result_data(result_data),
    .br_valid(br_valid), .br_tag(br_tag), .br_taken(br_taken), .br_addr(br_addr),
    .issue_ready(issue_ready), .drain(drain), .drained(drained)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) cycle <= cycle + 1;

  function automatic logic [`XLEN-1:0] alu_ref(logic [3:0] op, logic [`XLEN-1:0] a,
                                               logic [`XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (alu_type_t'(op))
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
      ALU_SLTU: return (a < b) ? 1 : 0;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return $signed(a) >>> sh;
      default:  return '0;
    endcase
  endfunction

  function automatic bit br_ref(logic [3:0] op, logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
    case (br_type_t'(op[2:0]))
      BR_EQ:   return a == b;
      BR_NE:   return a != b;
      BR_LT:   return $signed(a) < $signed(b);
      BR_GE:   return $signed(a) >= $signed(b);
      BR_LTU:  return a < b;
      BR_GEU:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // one half of the 64-bit product of the extended operands
  function automatic logic [`XLEN-1:0] mul_ref(logic [3:0] op, logic [`XLEN-1:0] a,
                                               logic [`XLEN-1:0] b);
    imul_type_t         t;
    logic [2*`XLEN-1:0] wa, wb, p;
    t  = imul_type_t'(op[1:0]);
    wa = {{`XLEN{1'b0}}, a};
    wb = {{`XLEN{1'b0}}, b};
    if (t == IMUL_MULH || t == IMUL_MULHSU) wa = {{`XLEN{a[`XLEN-1]}}, a};
    if (t == IMUL_MULH) wb = {{`XLEN{b[`XLEN-1]}}, b};
    p = wa * wb;
    return (t == IMUL_MUL) ? p[`XLEN-1:0] : p[2*`XLEN-1:`XLEN];
  endfunction

  task automatic compare_value(string name, string what, logic [`XLEN-1:0] exp_v,
                               logic [`XLEN-1:0] act_v);
    checks++;
    assert (exp_v === act_v) else begin
      value_errors++;
      $display("FAILED %s %s: expected 0x%h, actual 0x%h", name, what, exp_v, act_v);
    end
  endtask

  task automatic expect_true(bit cond, string msg);
    checks++;
    assert (cond) else begin
      other_errors++;
      $display("%s", msg);
    end
  endtask

  function automatic vec_t make_vec(string name, fu_sel_t fu, logic [3:0] op,
                                    logic [`XLEN-1:0] a, logic [`XLEN-1:0] b,
                                    logic [`XLEN-1:0] pc_v, logic [`XLEN-1:0] imm_v,
                                    int gap, int stalls);
    vec_t v;
    v = '{name, fu, op, a, b, pc_v, imm_v, next_tag, gap, stalls};
    next_tag = next_tag + 1'b1;
    return v;
  endfunction

  task automatic add_entry(string name, fu_sel_t fu, logic [3:0] op, logic [`XLEN-1:0] a,
                           logic [`XLEN-1:0] b, logic [`XLEN-1:0] pc_v = '0,
                           logic [`XLEN-1:0] imm_v = '0, int gap = 0, int stalls = -1);
    vec_table.push_back(make_vec(name, fu, op, a, b, pc_v, imm_v, gap, stalls));
  endtask

  // starts and ends on a falling edge
  task automatic issue_entry(vec_t v);
    int waited;
    int acc;
    issue = 1'b0;
    repeat (v.gap) @(negedge clock);
    fu_sel    = v.fu;
    alu_type  = alu_type_t'(v.op);
    br_type   = br_type_t'(v.op[2:0]);
    imul_type = imul_type_t'(v.op[1:0]);
    tag       = v.tag;
    in1       = v.a;
    in2       = v.b;
    pc        = v.pc;
    imm       = v.imm;
    issue     = 1'b1;
    waited    = 0;
    #1;
    while (!issue_ready && waited < WAIT_LIMIT) begin
      @(negedge clock);
      #1;
      waited++;
    end
    if (!issue_ready) begin
      expect_true(1'b0, $sformatf("issue of %s was never accepted", v.name));
      issue = 1'b0;
    end else begin
      acc = cycle + 1;  // the coming rising edge takes it
      if (v.stalls >= 0) compare_value(v.name, "stall cycles", v.stalls, waited);
      pend[v.tag]     = 1'b1;
      is_br[v.tag]    = (v.fu == FU_BRANCH);
      exp_name[v.tag] = v.name;
      exp_cyc[v.tag]  = acc;
      case (v.fu)
        FU_BRANCH: begin
          exp_tk[v.tag]  = br_ref(v.op, v.a, v.b);
          exp_val[v.tag] = v.pc + v.imm;
        end
        FU_IMUL: begin
          exp_val[v.tag] = mul_ref(v.op, v.a, v.b);
          exp_cyc[v.tag] = acc + LAT - 1;
          last_mul_cyc   = acc + LAT - 1;
        end
        default: exp_val[v.tag] = alu_ref(v.op, v.a, v.b);
      endcase
      @(negedge clock);
    end
  endtask

  function automatic int pending_count();
    int n;
    n = 0;
    for (int t = 0; t < NTAGS; t++) n += pend[t];
    return n;
  endfunction

  task automatic wait_results();
    int waited;
    issue  = 1'b0;
    waited = 0;
    while (pending_count() > 0 && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    expect_true(pending_count() == 0, "timed out waiting for outstanding results");
  endtask

  task automatic drain_and_check(string name);
    int          waited;
    int          exp_d;
    ctrl_state_t st;
    exp_d = (last_mul_cyc + 1 > cycle + 1) ? last_mul_cyc + 1 : cycle + 1;
    drain = 1'b1;
    #1;
    expect_true(!issue_ready, $sformatf("%s: issue_ready high while drain is raised", name));
    @(negedge clock);
    drain  = 1'b0;
    waited = 0;
    #1;
    while (!drained && waited < WAIT_LIMIT) begin
      expect_true(!issue_ready, $sformatf("%s: issue_ready rose before drained", name));
      @(negedge clock);
      #1;
      waited++;
    end
    if (!drained) begin
      st = u_exec_cluster.u_issue_ctrl.state;
      expect_true(1'b0, $sformatf("%s: timed out waiting for drained in %s", name, st.name()));
    end else begin
      compare_value(name, "drained cycle", exp_d, cycle);
      @(negedge clock);
      #1;
      expect_true(!drained, $sformatf("%s: drained lasted more than one cycle", name));
      expect_true(issue_ready, $sformatf("%s: issue_ready stayed low after drain", name));
    end
  endtask

  function automatic logic [3:0] random_op(fu_sel_t fu);
    case (fu)
      FU_BRANCH: return 4'($urandom_range(5));
      FU_IMUL:   return 4'($urandom_range(3));
      default:   return 4'($urandom_range(9));
    endcase
  endfunction

  always @(negedge clock) begin
    if (!reset) begin
      if (result_valid) begin
        expect_true(pend[result_tag] && !is_br[result_tag],
                    $sformatf("writeback with tag %0d that was not expected", result_tag));
        if (pend[result_tag] && !is_br[result_tag]) begin
          compare_value(exp_name[result_tag], "result cycle", exp_cyc[result_tag], cycle);
          compare_value(exp_name[result_tag], "result data", exp_val[result_tag], result_data);
          pend[result_tag] = 1'b0;
        end
      end
      if (br_valid) begin
        expect_true(pend[br_tag] && is_br[br_tag],
                    $sformatf("branch result with tag %0d that was not expected", br_tag));
        if (pend[br_tag] && is_br[br_tag]) begin
          compare_value(exp_name[br_tag], "branch cycle", exp_cyc[br_tag], cycle);
          compare_value(exp_name[br_tag], "taken", `XLEN'(exp_tk[br_tag]), `XLEN'(br_taken));
          compare_value(exp_name[br_tag], "target", exp_val[br_tag], br_addr);
          pend[br_tag] = 1'b0;
        end
      end
      for (int t = 0; t < NTAGS; t++) begin
        if (pend[t] && exp_cyc[t] < cycle) begin
          expect_true(1'b0, $sformatf("result of %s never arrived", exp_name[t]));
          pend[t] = 1'b0;
        end
      end
      expect_true(int'(u_exec_cluster.inflight) <= LAT, "more multiplies in flight than stages");
    end
  end

  initial begin
    void'($urandom(SEED));
    reset      = 1'b1;
    issue      = 1'b0;
    drain      = 1'b0;
    fu_sel     = FU_ALU;
    alu_type   = ALU_ADD;
    br_type    = BR_EQ;
    imul_type  = IMUL_MUL;
    tag        = '0;
    in1        = '0;
    in2        = '0;
    pc         = '0;
    imm        = '0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    #1;
    expect_true(!result_valid && !br_valid && !drained, "valid output high after reset");
    expect_true(issue_ready, "issue_ready low after reset");
    expect_true(u_exec_cluster.u_issue_ctrl.state == RUN, "controller not in RUN after reset");
    @(negedge clock);

    // alu corners
    add_entry("add overflow", FU_ALU, 4'(ALU_ADD), 32'h7fff_ffff, 32'h1);
    add_entry("sub wrap", FU_ALU, 4'(ALU_SUB), 32'h0, 32'h1);
    add_entry("slt sign", FU_ALU, 4'(ALU_SLT), 32'h8000_0000, 32'h7fff_ffff);
    add_entry("sltu sign", FU_ALU, 4'(ALU_SLTU), 32'h8000_0000, 32'h7fff_ffff);
    add_entry("slt neg", FU_ALU, 4'(ALU_SLT), 32'hffff_ffff, 32'h1);
    add_entry("sltu neg", FU_ALU, 4'(ALU_SLTU), 32'hffff_ffff, 32'h1);
    add_entry("xor", FU_ALU, 4'(ALU_XOR), 32'hdead_beef, 32'h0f0f_f0f0);
    add_entry("or", FU_ALU, 4'(ALU_OR), 32'h1234_0000, 32'h0000_5678);
    add_entry("and", FU_ALU, 4'(ALU_AND), 32'hf0f0_ff00, 32'h3c3c_0ff0);
    add_entry("sll 31", FU_ALU, 4'(ALU_SLL), 32'h0000_0003, 32'd31);
    add_entry("srl 31", FU_ALU, 4'(ALU_SRL), 32'h8000_0000, 32'd31);
    add_entry("sra 31", FU_ALU, 4'(ALU_SRA), 32'h8000_0000, 32'd31);
    add_entry("sra neg", FU_ALU, 4'(ALU_SRA), 32'hf000_0010, 32'h0000_0024);  // uses low 5 bits
    // branch corners with some negative imm
    add_entry("beq", FU_BRANCH, 4'(BR_EQ), 32'h55, 32'h55, 32'h1000, 32'hffff_fff0);
    add_entry("bne equal", FU_BRANCH, 4'(BR_NE), 32'h55, 32'h55, 32'h1004, 32'h20);
    add_entry("blt sign", FU_BRANCH, 4'(BR_LT), 32'h8000_0000, 32'h7fff_ffff, 32'h2000, 32'h8);
    add_entry("bge equal", FU_BRANCH, 4'(BR_GE), 32'hffff_ffff, 32'hffff_ffff, 32'h2004, 32'h4);
    add_entry("bltu sign", FU_BRANCH, 4'(BR_LTU), 32'hffff_ffff, 32'h1, 32'h3000, 32'h100);
    add_entry("bgeu sign", FU_BRANCH, 4'(BR_GEU), 32'h1, 32'hffff_ffff, 32'h3004, 32'hffff_f000);
    // multiply extremes back to back
    add_entry("mul min", FU_IMUL, 4'(IMUL_MUL), 32'h8000_0000, 32'hffff_ffff);
    add_entry("mulh min", FU_IMUL, 4'(IMUL_MULH), 32'h8000_0000, 32'hffff_ffff);
    add_entry("mulhsu min", FU_IMUL, 4'(IMUL_MULHSU), 32'h8000_0000, 32'hffff_ffff);
    add_entry("mulhu max", FU_IMUL, 4'(IMUL_MULHU), 32'hffff_ffff, 32'hffff_ffff);
    add_entry("mulh min sq", FU_IMUL, 4'(IMUL_MULH), 32'h8000_0000, 32'h8000_0000);
    for (int i = 0; i < 6; i++) begin
      add_entry($sformatf("random mul %0d", i), FU_IMUL, random_op(FU_IMUL), $urandom, $urandom);
    end
    // offers in the writeback slot of an earlier multiply
    add_entry("slot mul a", FU_IMUL, 4'(IMUL_MUL), 32'd7, 32'd9, '0, '0, LAT + 2, 0);
    add_entry("slot alu", FU_ALU, 4'(ALU_ADD), 32'd100, 32'd23, '0, '0, LAT - 2, 1);
    add_entry("slot mul b", FU_IMUL, 4'(IMUL_MULHU), 32'hffff_0000, 32'h10, '0, '0, LAT + 2, 0);
    add_entry("slot branch", FU_BRANCH, 4'(BR_NE), 32'd1, 32'd2, 32'h40, 32'h8, LAT - 2, 1);
    for (int i = 0; i < 10; i++) begin
      fu_sel_t f;
      f = fu_sel_t'(2'($urandom_range(2)));
      add_entry($sformatf("random mix %0d", i), f, random_op(f), $urandom, $urandom,
                $urandom, $urandom);
    end

    foreach (vec_table[i]) issue_entry(vec_table[i]);
    wait_results();

    drain_and_check("drain idle");
    for (int i = 0; i < 3; i++) begin
      issue_entry(make_vec($sformatf("drain mul %0d", i), FU_IMUL, random_op(FU_IMUL),
                           $urandom, $urandom, '0, '0, 0, 0));
    end
    issue = 1'b0;
    drain_and_check("drain busy");
    wait_results();

    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/exec_cluster.sv */
// ------------------------------
// integer execution cluster top
// alu, branch, multiplier, shared
// writeback port
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "exec_params.svh"

module exec_cluster import exec_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  // issue
  input  logic             issue,
  input  fu_sel_t          fu_sel,
  input  alu_type_t        alu_type,
  input  br_type_t         br_type,
  input  imul_type_t       imul_type,
  input  tag_t             tag,
  input  logic [`XLEN-1:0] in1,
  input  logic [`XLEN-1:0] in2,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] imm,
  // writeback
  output logic             result_valid,
  output tag_t             result_tag,
  output logic [`XLEN-1:0] result_data,
  // branch resolution
  output logic             br_valid,
  output tag_t             br_tag,
  output logic             br_taken,
  output logic [`XLEN-1:0] br_addr,
  // control
  output logic             issue_ready,
  input  logic             drain,
  output logic             drained
);

  logic                   alu_start, br_start, mul_start;
  logic                   mul_done, alu_valid;
  logic [`INFLIGHT_W-1:0] inflight;
  tag_t                   alu_tag, mul_tag;
  logic [`XLEN-1:0]       alu_out, mul_out;

  issue_ctrl u_issue_ctrl (
    .clock(clock), .reset(reset), .issue(issue), .fu_sel(fu_sel),
    .drain(drain), .count(inflight), .mul_done(mul_done),
    .issue_ready(issue_ready), .alu_start(alu_start), .br_start(br_start),
    .mul_start(mul_start), .drained(drained)
  );

  inflight_counter u_inflight_counter (
    .clock(clock), .reset(reset), .inc(mul_start), .dec(mul_done), .count(inflight)
  );

  alu u_alu (
    .clock(clock), .reset(reset), .start(alu_start), .alu_type(alu_type), .tag(tag),
    .in1(in1), .in2(in2), .valid(alu_valid), .out_tag(alu_tag), .out(alu_out)
  );

  branch_unit u_branch_unit (
    .clock(clock), .reset(reset), .start(br_start), .br_type(br_type), .tag(tag),
    .in1(in1), .in2(in2), .pc(pc), .imm(imm),
    .valid(br_valid), .out_tag(br_tag), .taken(br_taken), .target(br_addr)
  );

  imul u_imul (
    .clock(clock), .reset(reset), .start(mul_start), .imul_type(imul_type), .tag(tag),
    .in1(in1), .in2(in2), .done(mul_done), .out_tag(mul_tag), .out(mul_out)
  );

  // alu and multiplier never valid together, plain or-merge
  assign result_valid = alu_valid | mul_done;
  assign result_tag   = ({`TAG_WIDTH{alu_valid}} & alu_tag) |
                        ({`TAG_WIDTH{mul_done}} & mul_tag);
  assign result_data  = ({`XLEN{alu_valid}} & alu_out) |
                        ({`XLEN{mul_done}} & mul_out);

endmodule

`default_nettype wire

/* src/issue_ctrl.sv */
// ------------------------------
// issue control: writeback slot
// prediction, drain FSM, steering
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "exec_params.svh"

module issue_ctrl import exec_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   issue,
  input  fu_sel_t                fu_sel,
  input  logic                   drain,
  input  logic [`INFLIGHT_W-1:0] count,
  input  logic                   mul_done,
  output logic                   issue_ready,
  output logic                   alu_start,
  output logic                   br_start,
  output logic                   mul_start,
  output logic                   drained
);

  ctrl_state_t               state;
  logic [`IMUL_LATENCY-2:0]  mul_hist;  // bit k set: multiply accepted k+1 edges ago
  logic                      slot_busy;
  logic                      accept;

  // a multiply in the last history bit writes back right after the next edge,
  // the same cycle an alu issued now would
  assign slot_busy = mul_hist[`IMUL_LATENCY-2];

  assign issue_ready = (state == RUN) && !drain && !slot_busy;
  assign accept      = issue && issue_ready;

  assign alu_start = accept && (fu_sel == FU_ALU);
  assign br_start  = accept && (fu_sel == FU_BRANCH);
  assign mul_start = accept && (fu_sel == FU_IMUL);

  // nothing in flight and no product on the port
  assign drained = (state == DRAIN) && (count == '0) && !mul_done;

  always_ff @(posedge clock) begin
    if (reset) begin
      mul_hist <= '0;
    end else begin
      mul_hist[0] <= mul_start;
      for (int i = 1; i < `IMUL_LATENCY - 1; i++) mul_hist[i] <= mul_hist[i-1];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= RUN;
    end else begin
      case (state)
        RUN:     if (drain) state <= DRAIN;
        DRAIN:   if (drained) state <= RUN;
        default: state <= RUN;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/inflight_counter.sv */
// ------------------------------
// count of multiplies in flight
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "exec_params.svh"

module inflight_counter (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   inc,
  input  logic                   dec,
  output logic [`INFLIGHT_W-1:0] count
);

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({inc, dec})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/imul.sv */
// ------------------------------
// pipelined multiplier, signed
// and unsigned, hi/lo select
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "exec_params.svh"

module imul import exec_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  imul_type_t       imul_type,
  input  tag_t             tag,
  input  logic [`XLEN-1:0] in1,
  input  logic [`XLEN-1:0] in2,
  output logic             done,
  output tag_t             out_tag,
  output logic [`XLEN-1:0] out
);

  logic                      sign_a, sign_b;
  logic signed [`XLEN:0]     a_ext, b_ext;   // one extra bit for the sign
  logic signed [2*`XLEN+1:0] product;
  logic                      s1_valid;
  logic        [2*`XLEN-1:0] s1_prod, prod_out;
  tag_t                      s1_tag;
  logic                      s1_hi, hi_out;

  assign sign_a = (imul_type == IMUL_MULH) || (imul_type == IMUL_MULHSU);
  assign sign_b = (imul_type == IMUL_MULH);
  assign a_ext   = {sign_a & in1[`XLEN-1], in1};
  assign b_ext   = {sign_b & in2[`XLEN-1], in2};
  assign product = a_ext * b_ext;

  // first stage
  always_ff @(posedge clock) begin
    if (reset) s1_valid <= 1'b0;
    else       s1_valid <= start;
  end

  always_ff @(posedge clock) begin
    if (start) begin
      s1_prod <= product[2*`XLEN-1:0];
      s1_tag  <= tag;
      s1_hi   <= (imul_type != IMUL_MUL);
    end
  end

  delay_pipe #(.payload_t(logic [2*`XLEN-1:0]), .DEPTH(`IMUL_LATENCY-1)) u_prod_pipe (
    .clock(clock), .reset(reset),
    .in_valid(s1_valid), .in_data(s1_prod),
    .out_valid(done), .out_data(prod_out)
  );

  delay_pipe #(.payload_t(tag_t), .DEPTH(`IMUL_LATENCY-1)) u_tag_pipe (
    .clock(clock), .reset(reset),
    .in_valid(s1_valid), .in_data(s1_tag),
    .out_valid(), .out_data(out_tag)
  );

  delay_pipe #(.payload_t(logic), .DEPTH(`IMUL_LATENCY-1)) u_hi_pipe (
    .clock(clock), .reset(reset),
    .in_valid(s1_valid), .in_data(s1_hi),
    .out_valid(), .out_data(hi_out)
  );

  assign out = hi_out ? prod_out[2*`XLEN-1:`XLEN] : prod_out[`XLEN-1:0];

endmodule

`default_nettype wire

/* src/branch_unit.sv */
// ------------------------------
// branch compare, target adder
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "exec_params.svh"

module branch_unit import exec_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  br_type_t         br_type,
  input  tag_t             tag,
  input  logic [`XLEN-1:0] in1,
  input  logic [`XLEN-1:0] in2,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] imm,
  output logic             valid,
  output tag_t             out_tag,
  output logic             taken,
  output logic [`XLEN-1:0] target
);

  logic signed [`XLEN-1:0] s_in1, s_in2;
  logic                    eq, lt, ltu;
  logic                    cond;

  assign s_in1 = in1;
  assign s_in2 = in2;
  assign eq    = in1 == in2;
  assign lt    = s_in1 < s_in2;
  assign ltu   = in1 < in2;

  always_comb begin
    case (br_type)
      BR_EQ:   cond = eq;
      BR_NE:   cond = !eq;
      BR_LT:   cond = lt;
      BR_GE:   cond = !lt;   // ge includes equal
      BR_LTU:  cond = ltu;
      BR_GEU:  cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) valid <= 1'b0;
    else       valid <= start;
  end

  always_ff @(posedge clock) begin
    if (start) begin
      taken   <= cond;
      target  <= pc + imm;
      out_tag <= tag;
    end
  end

endmodule

`default_nettype wire

/* src/alu.sv */
// ------------------------------
// registered integer alu,
// ten rv32i register ops
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "exec_params.svh"

module alu import exec_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  alu_type_t        alu_type,
  input  tag_t             tag,
  input  logic [`XLEN-1:0] in1,
  input  logic [`XLEN-1:0] in2,
  output logic             valid,
  output tag_t             out_tag,
  output logic [`XLEN-1:0] out
);

  logic signed [`XLEN-1:0] s_in1, s_in2;
  logic        [4:0]       shamt;
  logic        [`XLEN-1:0] result;

  assign s_in1 = in1;
  assign s_in2 = in2;
  assign shamt = in2[4:0];

  always_comb begin
    case (alu_type)
      ALU_ADD:  result = in1 + in2;
      ALU_SUB:  result = in1 - in2;
      ALU_SLT:  result = {{(`XLEN-1){1'b0}}, s_in1 < s_in2};
      ALU_SLTU: result = {{(`XLEN-1){1'b0}}, in1 < in2};
      ALU_XOR:  result = in1 ^ in2;
      ALU_OR:   result = in1 | in2;
      ALU_AND:  result = in1 & in2;
      ALU_SLL:  result = in1 << shamt;
      ALU_SRL:  result = in1 >> shamt;
      ALU_SRA:  result = s_in1 >>> shamt;
      default:  result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) valid <= 1'b0;
    else       valid <= start;
  end

  always_ff @(posedge clock) begin
    if (start) begin
      out     <= result;
      out_tag <= tag;
    end
  end

endmodule

`default_nettype wire

/* src/delay_pipe.sv */
// ------------------------------
// shift pipeline, valid bit per
// stage, any payload type
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module delay_pipe #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  logic [DEPTH-1:0] valid_q;
  payload_t         data_q [DEPTH];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++) valid_q[i] <= valid_q[i-1];
    end
  end

  // payload only moves with its valid bit
  always_ff @(posedge clock) begin
    if (in_valid) data_q[0] <= in_data;
    for (int i = 1; i < DEPTH; i++) begin
      if (valid_q[i-1]) data_q[i] <= data_q[i-1];
    end
  end

  assign out_valid = valid_q[DEPTH-1];
  assign out_data  = data_q[DEPTH-1];

endmodule

`default_nettype wire

/* src/exec_pkg.sv */
// ------------------------------
// unit select, operation enums,
// reorder tag, controller states
// ------------------------------
`default_nettype none

`include "exec_params.svh"

package exec_pkg;

  typedef enum logic [1:0] {
    FU_ALU,
    FU_BRANCH,
    FU_IMUL
  } fu_sel_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_type_t;

  typedef enum logic [2:0] {
    BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_type_t;

  typedef enum logic [1:0] {
    IMUL_MUL, IMUL_MULH, IMUL_MULHSU, IMUL_MULHU
  } imul_type_t;

  typedef logic [`TAG_WIDTH-1:0] tag_t;

  typedef enum logic {RUN, DRAIN} ctrl_state_t;

endpackage

`default_nettype wire

/* src/exec_params.svh */
// ------------------------------
// widths and multiplier latency
// for the execution cluster
// ------------------------------
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

`define XLEN          32
`define TAG_WIDTH     4
`define IMUL_LATENCY  5  // at least 2

// in-flight multiply count, 0 to IMUL_LATENCY
`define INFLIGHT_W    $clog2(`IMUL_LATENCY + 1)

`endif
